// File: axi_link_pkg.sv
// Link widths, AXI channel payload structs and the two link frame layouts
package axi_link_pkg;

  ////////////////////////////////////////////////////////////
  // Widths

  localparam int ID_W     = 4;
  localparam int ADDR_W   = 32;
  localparam int DATA_W   = 32;
  localparam int STRB_W   = 4;
  localparam int CREDIT_W = 8;
  localparam int PHY_W    = 80;

  ////////////////////////////////////////////////////////////
  // Channel payloads

  // Read address, 49 bits
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [2:0]        size;
    logic [7:0]        len;
    logic [1:0]        burst;
    logic [ADDR_W-1:0] addr;
  } ar_t;

  // Write address has the read address layout
  typedef ar_t aw_t;

  // Write data, 41 bits
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } w_t;

  // Read data, 39 bits
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    logic              last;
    logic [1:0]        resp;
  } r_t;

  // Write response, 6 bits
  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [1:0]      resp;
  } b_t;

  ////////////////////////////////////////////////////////////
  // Link frames, two PHY words each, phy1 in the upper half

  localparam int RX_PAD_W = 2 * PHY_W - (1 + $bits(ar_t)) - (1 + $bits(aw_t))
                            - (1 + $bits(w_t)) - 2;
  localparam int TX_PAD_W = 2 * PHY_W - (1 + $bits(r_t)) - (1 + $bits(b_t)) - 3;

  // Far die to this die
  typedef struct packed {
    logic [RX_PAD_W-1:0] pad;
    logic                ar_push;
    ar_t                 ar;
    logic                aw_push;
    aw_t                 aw;
    logic                w_push;
    w_t                  w;
    logic                r_credit;
    logic                b_credit;
  } link_rx_frame_t;

  // This die to far die
  typedef struct packed {
    logic [TX_PAD_W-1:0] pad;
    logic                r_push;
    r_t                  r;
    logic                b_push;
    b_t                  b;
    logic                ar_credit;
    logic                aw_credit;
    logic                w_credit;
  } link_tx_frame_t;

endpackage

// File: link_online_delay.sv
// Programmable delay from a link online input to its active flag
`timescale 1ns/1ps

module link_online_delay #(
  parameter int DELAY_W = 16
) (
  input  logic               clk_wr,
  input  logic               arst_n,
  input  logic               online,
  input  logic [DELAY_W-1:0] delay_value,
  output logic               active
);

  logic [DELAY_W-1:0] count;

  // Count stops at delay_value, so it never wraps
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      count  <= '0;
      active <= 1'b0;
    end else if (!online) begin
      count  <= '0;
      active <= 1'b0;
    end else begin
      if (count < delay_value) begin
        count <= count + 1'b1;
      end
      // Set on the edge where the count already equals the delay
      active <= (count >= delay_value);
    end
  end

endmodule

// File: link_rx_fifo.sv
// Receive channel buffer with link push, user pop and per-pop credit return
`timescale 1ns/1ps

module link_rx_fifo #(
  parameter type PAYLOAD_T = logic,
  parameter int  DEPTH     = 8
) (
  input  logic     clk_wr,
  input  logic     arst_n,
  input  logic     active,
  input  logic     push,
  input  PAYLOAD_T push_data,
  input  logic     ready,
  output PAYLOAD_T data,
  output logic     valid,
  output logic     credit
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  PAYLOAD_T         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             wr_en;
  logic             rd_en;

  // Pointer step with wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  // Link pushes are dropped until the receive side is active
  assign wr_en = push && active;
  assign rd_en = valid && ready;

  // Head entry
  assign valid = (count != '0);
  assign data  = mem[rd_ptr];

  ////////////////////////////////////////////////////////////
  // Storage

  always_ff @(posedge clk_wr) begin
    if (wr_en) begin
      mem[wr_ptr] <= push_data;
    end
  end

  ////////////////////////////////////////////////////////////
  // Pointers, fill level and credit pulse

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // One slot freed per pop, returned to the far side next cycle
      credit <= rd_en;
    end
  end

endmodule

// File: link_tx_credit.sv
// Transmit credit counter that gates user ready for one response channel
`timescale 1ns/1ps

module link_tx_credit #(
  parameter type PAYLOAD_T = logic
) (
  input  logic                              clk_wr,
  input  logic                              arst_n,
  input  logic                              active,
  input  logic [axi_link_pkg::CREDIT_W-1:0] init_credit,
  input  logic                              credit_in,
  input  logic                              valid,
  input  PAYLOAD_T                          data,
  output logic                              ready,
  output logic                              send,
  output PAYLOAD_T                          send_data
);

  logic [axi_link_pkg::CREDIT_W-1:0] credit_cnt;
  logic [axi_link_pkg::CREDIT_W-1:0] credit_avail;
  logic                              active_q;

  // First active cycle sees the init value before the counter holds it
  assign credit_avail = active_q ? credit_cnt : init_credit;

  assign ready     = active && (credit_avail != '0);
  assign send      = valid && ready;
  assign send_data = data;

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      active_q   <= 1'b0;
      credit_cnt <= '0;
    end else begin
      active_q <= active;
      if (!active) begin
        credit_cnt <= '0;
      end else begin
        // Returned credit and a transfer in one cycle cancel out
        case ({credit_in, send})
          2'b10:   credit_cnt <= credit_avail + 1'b1;
          2'b01:   credit_cnt <= credit_avail - 1'b1;
          default: credit_cnt <= credit_avail;
        endcase
      end
    end
  end

endmodule

// File: link_frame_codec.sv
// Link frame codec with registered rx unpacking and registered tx packing
`timescale 1ns/1ps

module link_frame_codec (
  input  logic                           clk_wr,
  input  logic                           arst_n,
  // PHY words
  input  logic [axi_link_pkg::PHY_W-1:0] rx_phy0,
  input  logic [axi_link_pkg::PHY_W-1:0] rx_phy1,
  output logic [axi_link_pkg::PHY_W-1:0] tx_phy0,
  output logic [axi_link_pkg::PHY_W-1:0] tx_phy1,
  // Credits from the receive buffers
  input  logic                           ar_credit,
  input  logic                           aw_credit,
  input  logic                           w_credit,
  // Responses from the credit gates
  input  logic                           r_send,
  input  axi_link_pkg::r_t               r_data,
  input  logic                           b_send,
  input  axi_link_pkg::b_t               b_data,
  // Requests to the receive buffers
  output logic                           ar_push,
  output axi_link_pkg::ar_t              ar_data,
  output logic                           aw_push,
  output axi_link_pkg::aw_t              aw_data,
  output logic                           w_push,
  output axi_link_pkg::w_t               w_data,
  // Credits to the credit gates
  output logic                           r_credit,
  output logic                           b_credit
);

  axi_link_pkg::link_rx_frame_t rx_frame_q;
  axi_link_pkg::link_tx_frame_t tx_frame;
  axi_link_pkg::link_tx_frame_t tx_frame_q;

  ////////////////////////////////////////////////////////////
  // Receive direction

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      rx_frame_q <= '0;
    end else begin
      rx_frame_q <= axi_link_pkg::link_rx_frame_t'({rx_phy1, rx_phy0});
    end
  end

  assign ar_push  = rx_frame_q.ar_push;
  assign ar_data  = rx_frame_q.ar;
  assign aw_push  = rx_frame_q.aw_push;
  assign aw_data  = rx_frame_q.aw;
  assign w_push   = rx_frame_q.w_push;
  assign w_data   = rx_frame_q.w;
  assign r_credit = rx_frame_q.r_credit;
  assign b_credit = rx_frame_q.b_credit;

  ////////////////////////////////////////////////////////////
  // Transmit direction

  // Payload fields stay zero unless their pushbit is set
  always_comb begin
    tx_frame           = '0;
    tx_frame.r_push    = r_send;
    tx_frame.b_push    = b_send;
    tx_frame.ar_credit = ar_credit;
    tx_frame.aw_credit = aw_credit;
    tx_frame.w_credit  = w_credit;
    if (r_send) begin
      tx_frame.r = r_data;
    end
    if (b_send) begin
      tx_frame.b = b_data;
    end
  end

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_frame_q <= '0;
    end else begin
      tx_frame_q <= tx_frame;
    end
  end

  assign {tx_phy1, tx_phy0} = tx_frame_q;

endmodule

// File: axi_link_slave_top.sv
// AXI slave side link bridge top with channel buffers, credit senders, online delays and codec
`timescale 1ns/1ps

module axi_link_slave_top #(
  parameter int AR_DEPTH = 8,
  parameter int AW_DEPTH = 8,
  parameter int W_DEPTH  = 16,
  parameter int DELAY_W  = 16
) (
  input  logic                                  clk_wr,
  input  logic                                  arst_n,
  // Control
  input  logic                                  tx_online,
  input  logic                                  rx_online,
  input  logic [axi_link_pkg::CREDIT_W-1:0]     init_r_credit,
  input  logic [axi_link_pkg::CREDIT_W-1:0]     init_b_credit,
  input  logic [DELAY_W-1:0]                    delay_x_value,
  input  logic [DELAY_W-1:0]                    delay_y_value,
  // PHY
  input  logic [axi_link_pkg::PHY_W-1:0]        rx_phy0,
  input  logic [axi_link_pkg::PHY_W-1:0]        rx_phy1,
  output logic [axi_link_pkg::PHY_W-1:0]        tx_phy0,
  output logic [axi_link_pkg::PHY_W-1:0]        tx_phy1,
  // Requests to the local slave
  output axi_link_pkg::ar_t                     user_ar,
  output logic                                  user_arvalid,
  input  logic                                  user_arready,
  output axi_link_pkg::aw_t                     user_aw,
  output logic                                  user_awvalid,
  input  logic                                  user_awready,
  output axi_link_pkg::w_t                      user_w,
  output logic                                  user_wvalid,
  input  logic                                  user_wready,
  // Responses from the local slave
  input  axi_link_pkg::r_t                      user_r,
  input  logic                                  user_rvalid,
  output logic                                  user_rready,
  input  axi_link_pkg::b_t                      user_b,
  input  logic                                  user_bvalid,
  output logic                                  user_bready
);

  ////////////////////////////////////////////////////////////
  // Interconnect

  logic              rx_active;
  logic              tx_active;

  logic              ar_push;
  axi_link_pkg::ar_t ar_data;
  logic              ar_credit;
  logic              aw_push;
  axi_link_pkg::aw_t aw_data;
  logic              aw_credit;
  logic              w_push;
  axi_link_pkg::w_t  w_data;
  logic              w_credit;

  logic              r_send;
  axi_link_pkg::r_t  r_data;
  logic              r_credit;
  logic              b_send;
  axi_link_pkg::b_t  b_data;
  logic              b_credit;

  ////////////////////////////////////////////////////////////
  // Online qualification, x for receive and y for transmit

  link_online_delay #(.DELAY_W(DELAY_W)) u_rx_delay (
    .clk_wr(clk_wr), .arst_n(arst_n), .online(rx_online),
    .delay_value(delay_x_value), .active(rx_active)
  );

  link_online_delay #(.DELAY_W(DELAY_W)) u_tx_delay (
    .clk_wr(clk_wr), .arst_n(arst_n), .online(tx_online),
    .delay_value(delay_y_value), .active(tx_active)
  );

  ////////////////////////////////////////////////////////////
  // Receive buffers

  link_rx_fifo #(.PAYLOAD_T(axi_link_pkg::ar_t), .DEPTH(AR_DEPTH)) u_ar_fifo (
    .clk_wr(clk_wr), .arst_n(arst_n), .active(rx_active),
    .push(ar_push), .push_data(ar_data), .ready(user_arready),
    .data(user_ar), .valid(user_arvalid), .credit(ar_credit)
  );

  link_rx_fifo #(.PAYLOAD_T(axi_link_pkg::aw_t), .DEPTH(AW_DEPTH)) u_aw_fifo (
    .clk_wr(clk_wr), .arst_n(arst_n), .active(rx_active),
    .push(aw_push), .push_data(aw_data), .ready(user_awready),
    .data(user_aw), .valid(user_awvalid), .credit(aw_credit)
  );

  link_rx_fifo #(.PAYLOAD_T(axi_link_pkg::w_t), .DEPTH(W_DEPTH)) u_w_fifo (
    .clk_wr(clk_wr), .arst_n(arst_n), .active(rx_active),
    .push(w_push), .push_data(w_data), .ready(user_wready),
    .data(user_w), .valid(user_wvalid), .credit(w_credit)
  );

  ////////////////////////////////////////////////////////////
  // Transmit credit gates

  link_tx_credit #(.PAYLOAD_T(axi_link_pkg::r_t)) u_r_credit (
    .clk_wr(clk_wr), .arst_n(arst_n), .active(tx_active),
    .init_credit(init_r_credit), .credit_in(r_credit),
    .valid(user_rvalid), .data(user_r),
    .ready(user_rready), .send(r_send), .send_data(r_data)
  );

  link_tx_credit #(.PAYLOAD_T(axi_link_pkg::b_t)) u_b_credit (
    .clk_wr(clk_wr), .arst_n(arst_n), .active(tx_active),
    .init_credit(init_b_credit), .credit_in(b_credit),
    .valid(user_bvalid), .data(user_b),
    .ready(user_bready), .send(b_send), .send_data(b_data)
  );

  ////////////////////////////////////////////////////////////
  // PHY framing

  link_frame_codec u_codec (
    .clk_wr(clk_wr), .arst_n(arst_n),
    .rx_phy0(rx_phy0), .rx_phy1(rx_phy1),
    .tx_phy0(tx_phy0), .tx_phy1(tx_phy1),
    .ar_credit(ar_credit), .aw_credit(aw_credit), .w_credit(w_credit),
    .r_send(r_send), .r_data(r_data), .b_send(b_send), .b_data(b_data),
    .ar_push(ar_push), .ar_data(ar_data),
    .aw_push(aw_push), .aw_data(aw_data),
    .w_push(w_push), .w_data(w_data),
    .r_credit(r_credit), .b_credit(b_credit)
  );

endmodule

// File: axi_link_assertions.sv
// Concurrent checks for buffer overflow, credit underflow and ready while inactive, with binds
`timescale 1ns/1ps

module axi_link_assertions (
  input logic                              clk_wr,
  input logic                              arst_n,
  input logic                              push,
  input logic                              full,
  input logic                              cnt_live,
  input logic [axi_link_pkg::CREDIT_W-1:0] credit_cnt,
  input logic [axi_link_pkg::CREDIT_W-1:0] init_credit,
  input logic                              active,
  input logic                              ready
);

  // Far side only pushes into free slots
  no_full_push: assert property (@(posedge clk_wr) disable iff (!arst_n) !(push && full))
    else $error("push into a full receive buffer");

  // Running counter moves by at most one per cycle and never wraps from zero
  no_credit_wrap: assert property (@(posedge clk_wr) disable iff (!arst_n)
                                   cnt_live |=> (int'(credit_cnt) <= int'($past(credit_cnt)) + 1))
    else $error("credit counter wrapped below zero");

  // Ready stays low while inactive and restarts from the initial credit
  no_idle_ready: assert property (@(posedge clk_wr) disable iff (!arst_n)
                                  !active |-> !ready ##1
                                  (!active || (ready == (init_credit != '0))))
    else $error("ready high while the link is inactive or not from the initial credit");

endmodule

bind link_rx_fifo axi_link_assertions u_rx_checks (
  .clk_wr(clk_wr), .arst_n(arst_n), .push(wr_en), .full(count == CNT_W'(DEPTH)),
  .cnt_live(1'b0), .credit_cnt('0), .init_credit('0), .active(active), .ready(1'b0)
);

bind link_tx_credit axi_link_assertions u_tx_checks (
  .clk_wr(clk_wr), .arst_n(arst_n), .push(1'b0), .full(1'b0),
  .cnt_live(active && active_q), .credit_cnt(credit_cnt), .init_credit(init_credit),
  .active(active), .ready(ready)
);

// File: tb_axi_link_slave.sv
// Testbench for the AXI link slave bridge with stimulus table, reference queues and watchdog
`timescale 1ns/1ps

module tb_axi_link_slave;

  localparam int AR_DEPTH = 8;
  localparam int AW_DEPTH = 8;
  localparam int W_DEPTH  = 16;
  localparam int DELAY_W  = 16;
  localparam int CLK_NS   = 20;
  localparam int INIT_R   = 4;
  localparam int INIT_B   = 3;
  localparam int DELAY_X  = 3;
  localparam int DELAY_Y  = 5;

  // Row kinds
  localparam int K_RESET = 0;
  localparam int K_GATE  = 1;
  localparam int K_DELAY = 2;
  localparam int K_RX    = 3;
  localparam int K_TX    = 4;

  // Channels
  localparam int CH_AR = 0;
  localparam int CH_AW = 1;
  localparam int CH_W  = 2;
  localparam int CH_R  = 3;
  localparam int CH_B  = 4;

  logic                              clk_wr = 1'b0;
  logic                              arst_n;
  logic                              tx_online;
  logic                              rx_online;
  logic [axi_link_pkg::CREDIT_W-1:0] init_r_credit;
  logic [axi_link_pkg::CREDIT_W-1:0] init_b_credit;
  logic [DELAY_W-1:0]                delay_x_value;
  logic [DELAY_W-1:0]                delay_y_value;
  logic [axi_link_pkg::PHY_W-1:0]    rx_phy0;
  logic [axi_link_pkg::PHY_W-1:0]    rx_phy1;
  logic [axi_link_pkg::PHY_W-1:0]    tx_phy0;
  logic [axi_link_pkg::PHY_W-1:0]    tx_phy1;
  axi_link_pkg::ar_t                 user_ar;
  logic                              user_arvalid;
  logic                              user_arready;
  axi_link_pkg::aw_t                 user_aw;
  logic                              user_awvalid;
  logic                              user_awready;
  axi_link_pkg::w_t                  user_w;
  logic                              user_wvalid;
  logic                              user_wready;
  axi_link_pkg::r_t                  user_r;
  logic                              user_rvalid;
  logic                              user_rready;
  axi_link_pkg::b_t                  user_b;
  logic                              user_bvalid;
  logic                              user_bready;

  // Reference queues, plus the sampling point at which each entry is due
  axi_link_pkg::ar_t ar_q[$];
  axi_link_pkg::aw_t aw_q[$];
  axi_link_pkg::w_t  w_q[$];
  axi_link_pkg::r_t  r_q[$];
  axi_link_pkg::b_t  b_q[$];
  int                when_q[$];

  // Stimulus table
  string row_name[$];
  int    row_kind[$];
  int    row_chan[$];
  int    row_stall[$];
  int    row_count[$];
  int    row_expect[$];

  int          checks;
  int          errors;
  int          failed;
  logic [31:0] lfsr_state;

  always #(CLK_NS / 2) clk_wr = ~clk_wr;

  axi_link_slave_top #(
    .AR_DEPTH(AR_DEPTH), .AW_DEPTH(AW_DEPTH), .W_DEPTH(W_DEPTH), .DELAY_W(DELAY_W)
  ) DUT (.*);

  ////////////////////////////////////////////////////////////
  // Random payload bits, taps 32 22 2 1

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
    return v;
  endfunction

  ////////////////////////////////////////////////////////////
  // Compare tasks

  task automatic note_result(input string name, input bit ok, input string exp, input string act);
    checks++;
    if (!ok) begin
      errors++;
      $display("ERROR %s: expected %s, actual %s", name, exp, act);
    end
  endtask

  task automatic fail_note(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic check_ar(input string name, input axi_link_pkg::ar_t exp,
                          input axi_link_pkg::ar_t act);
    note_result(name, exp === act, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic check_aw(input string name, input axi_link_pkg::aw_t exp,
                          input axi_link_pkg::aw_t act);
    note_result(name, exp === act, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic check_w(input string name, input axi_link_pkg::w_t exp,
                         input axi_link_pkg::w_t act);
    note_result(name, exp === act, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic check_r(input string name, input axi_link_pkg::r_t exp,
                         input axi_link_pkg::r_t act);
    note_result(name, exp === act, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic check_b(input string name, input axi_link_pkg::b_t exp,
                         input axi_link_pkg::b_t act);
    note_result(name, exp === act, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    note_result(name, exp === act, $sformatf("%b", exp), $sformatf("%b", act));
  endtask

  task automatic check_int(input string name, input int exp, input int act);
    note_result(name, exp == act, $sformatf("%0d", exp), $sformatf("%0d", act));
  endtask

  ////////////////////////////////////////////////////////////
  // Row runners

  task automatic add_row(input string name, input int kind, input int chan,
                         input int stall, input int count, input int expect_n);
    row_name.push_back(name);
    row_kind.push_back(kind);
    row_chan.push_back(chan);
    row_stall.push_back(stall);
    row_count.push_back(count);
    row_expect.push_back(expect_n);
  endtask

  task automatic set_ready(input int chan, input logic val);
    case (chan)
      CH_AR:   user_arready <= val;
      CH_AW:   user_awready <= val;
      default: user_wready  <= val;
    endcase
  endtask

  task automatic run_reset(input string name);
    @(negedge clk_wr);
    check_bit({name, " valid"}, 1'b0, user_arvalid | user_awvalid | user_wvalid);
    check_bit({name, " ready"}, 1'b0, user_rready | user_bready);
    check_bit({name, " tx_phy"}, 1'b0, |{tx_phy1, tx_phy0});
  endtask

  task automatic run_gate(input string name, input int exp);
    axi_link_pkg::link_rx_frame_t f;
    logic [63:0]                  bits;
    int                           seen;
    seen = 0;
    bits = rand_bits($bits(axi_link_pkg::ar_t));
    f = '0;
    f.ar_push = 1'b1;
    f.ar = bits[$bits(axi_link_pkg::ar_t)-1:0];
    @(posedge clk_wr);
    {rx_phy1, rx_phy0} <= f;
    @(posedge clk_wr);
    {rx_phy1, rx_phy0} <= '0;
    repeat (6) begin
      @(negedge clk_wr);
      if (user_arvalid) seen++;
    end
    check_int(name, exp, seen);
    // Receive side comes up for the rows that follow
    @(posedge clk_wr);
    rx_online <= 1'b1;
    repeat (DELAY_X + 4) @(posedge clk_wr);
  endtask

  task automatic run_delay(input string name, input int delay, input int exp);
    int j;
    int seen;
    seen = -1;
    @(posedge clk_wr);
    tx_online <= 1'b1;
    for (j = 0; j < delay + 8; j++) begin
      @(negedge clk_wr);
      // Online is first sampled high one edge after it is driven
      if (user_rready && seen < 0) seen = j - 1;
      @(posedge clk_wr);
    end
    check_int(name, exp, seen);
  endtask

  task automatic run_rx(input string name, input int chan, input int stall,
                        input int n, input int exp);
    axi_link_pkg::link_rx_frame_t f;
    axi_link_pkg::link_tx_frame_t t_f;
    logic [63:0]                  bits;
    logic                         v;
    logic                         cr;
    logic                         pop;
    logic                         pop_d1;
    logic                         pop_d2;
    int                           pops;
    int                           t;
    pops = 0;
    pop = 1'b0;
    pop_d1 = 1'b0;
    for (t = 0; t < n + stall + 8; t++) begin
      @(posedge clk_wr);
      f = '0;
      if (t < n) begin
        case (chan)
          CH_AR: begin
            bits = rand_bits($bits(axi_link_pkg::ar_t));
            f.ar_push = 1'b1;
            f.ar = bits[$bits(axi_link_pkg::ar_t)-1:0];
            ar_q.push_back(f.ar);
          end
          CH_AW: begin
            bits = rand_bits($bits(axi_link_pkg::aw_t));
            f.aw_push = 1'b1;
            f.aw = bits[$bits(axi_link_pkg::aw_t)-1:0];
            aw_q.push_back(f.aw);
          end
          default: begin
            bits = rand_bits($bits(axi_link_pkg::w_t));
            f.w_push = 1'b1;
            f.w = bits[$bits(axi_link_pkg::w_t)-1:0];
            w_q.push_back(f.w);
          end
        endcase
        when_q.push_back(t + 2);
      end
      {rx_phy1, rx_phy0} <= f;
      set_ready(chan, t >= stall);
      @(negedge clk_wr);
      t_f = {tx_phy1, tx_phy0};
      pop_d2 = pop_d1;
      pop_d1 = pop;
      case (chan)
        CH_AR: begin
          v = user_arvalid;
          cr = t_f.ar_credit;
        end
        CH_AW: begin
          v = user_awvalid;
          cr = t_f.aw_credit;
        end
        default: begin
          v = user_wvalid;
          cr = t_f.w_credit;
        end
      endcase
      // Credit shows two sampling points after the pop decision
      check_bit({name, " credit"}, pop_d2, cr);
      if (stall > 0 && t == stall) check_bit({name, " held"}, 1'b1, v);
      pop = v && (t >= stall);
      if (pop && when_q.size() == 0) begin
        fail_note({name, ": entry at the user port with nothing sent"});
      end else if (pop) begin
        pops++;
        case (chan)
          CH_AR:   check_ar(name, ar_q.pop_front(), user_ar);
          CH_AW:   check_aw(name, aw_q.pop_front(), user_aw);
          default: check_w(name, w_q.pop_front(), user_w);
        endcase
        if (stall == 0) begin
          check_int({name, " latency"}, when_q.pop_front(), t);
        end else begin
          void'(when_q.pop_front());
        end
      end
    end
    check_int(name, exp, pops);
  endtask

  task automatic run_tx(input string name, input int chan, input int n, input int exp);
    axi_link_pkg::link_rx_frame_t f;
    axi_link_pkg::link_tx_frame_t t_f;
    logic [63:0]                  bits;
    axi_link_pkg::r_t             rp;
    axi_link_pkg::b_t             bp;
    logic                         go;
    logic                         due;
    int                           sent;
    int                           t;
    sent = 0;
    go = 1'b1;
    for (t = 0; t < n + 20; t++) begin
      @(posedge clk_wr);
      // New payload only after the previous one was taken
      if (go && chan == CH_R) begin
        bits = rand_bits($bits(axi_link_pkg::r_t));
        rp = bits[$bits(axi_link_pkg::r_t)-1:0];
        user_r <= rp;
        user_rvalid <= 1'b1;
      end else if (go) begin
        bits = rand_bits($bits(axi_link_pkg::b_t));
        bp = bits[$bits(axi_link_pkg::b_t)-1:0];
        user_b <= bp;
        user_bvalid <= 1'b1;
      end
      f = '0;
      f.r_credit = (chan == CH_R) && (t == n + 8);
      f.b_credit = (chan == CH_B) && (t == n + 8);
      {rx_phy1, rx_phy0} <= f;
      @(negedge clk_wr);
      t_f = {tx_phy1, tx_phy0};
      if (t == n + 8) check_int({name, " before credit"}, n, sent);
      go = (chan == CH_R) ? user_rready : user_bready;
      if (go) begin
        sent++;
        when_q.push_back(t + 1);
        if (chan == CH_R) r_q.push_back(rp);
        else b_q.push_back(bp);
      end
      due = (chan == CH_R) ? t_f.r_push : t_f.b_push;
      if (due && when_q.size() == 0) begin
        fail_note({name, ": response on tx_phy without a user transfer"});
      end else if (due) begin
        check_int({name, " latency"}, when_q.pop_front(), t);
        if (chan == CH_R) check_r(name, r_q.pop_front(), t_f.r);
        else check_b(name, b_q.pop_front(), t_f.b);
      end
    end
    @(posedge clk_wr);
    user_rvalid <= 1'b0;
    user_bvalid <= 1'b0;
    check_int(name, exp, sent);
    check_bit({name, " ready low"}, 1'b0, go);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    int i;
    int err_before;
    arst_n = 1'b0;
    tx_online = 1'b0;
    rx_online = 1'b0;
    init_r_credit = axi_link_pkg::CREDIT_W'(INIT_R);
    init_b_credit = axi_link_pkg::CREDIT_W'(INIT_B);
    delay_x_value = DELAY_W'(DELAY_X);
    delay_y_value = DELAY_W'(DELAY_Y);
    rx_phy0 = '0;
    rx_phy1 = '0;
    user_arready = 1'b1;
    user_awready = 1'b1;
    user_wready = 1'b1;
    user_r = '0;
    user_rvalid = 1'b0;
    user_b = '0;
    user_bvalid = 1'b0;
    lfsr_state = 32'h4fd7;
    checks = 0;
    errors = 0;
    failed = 0;
    add_row("reset_idle", K_RESET, CH_AR, 0, 0, 0);
    add_row("rx_gate_offline", K_GATE, CH_AR, 0, 1, 0);
    add_row("tx_online_delay", K_DELAY, CH_R, 0, DELAY_Y, DELAY_Y);
    add_row("ar_order", K_RX, CH_AR, 0, 6, 6);
    add_row("aw_order", K_RX, CH_AW, 0, 6, 6);
    add_row("w_order", K_RX, CH_W, 0, 10, 10);
    add_row("w_backpressure", K_RX, CH_W, W_DEPTH + 4, W_DEPTH, W_DEPTH);
    add_row("r_credit", K_TX, CH_R, 0, INIT_R, INIT_R + 1);
    add_row("b_credit", K_TX, CH_B, 0, INIT_B, INIT_B + 1);
    repeat (8) @(posedge clk_wr);
    arst_n <= 1'b1;
    for (i = 0; i < row_name.size(); i++) begin
      err_before = errors;
      case (row_kind[i])
        K_RESET: run_reset(row_name[i]);
        K_GATE:  run_gate(row_name[i], row_expect[i]);
        K_DELAY: run_delay(row_name[i], row_count[i], row_expect[i]);
        K_RX:    run_rx(row_name[i], row_chan[i], row_stall[i], row_count[i], row_expect[i]);
        default: run_tx(row_name[i], row_chan[i], row_count[i], row_expect[i]);
      endcase
      if (errors != err_before) failed++;
      $display("test %s %s", row_name[i], (errors == err_before) ? "ok" : "FAILED");
    end
    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             row_name.size(), failed, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    #1;
    #(row_name.size() * 200 * CLK_NS);
    $display("timeout: the tests did not finish in the allowed time");
    $display("sim failed");
    $finish;
  end

endmodule

// File: src.f
axi_link_pkg.sv
link_online_delay.sv
link_rx_fifo.sv
link_tx_credit.sv
link_frame_codec.sv
axi_link_slave_top.sv
axi_link_assertions.sv
tb_axi_link_slave.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_axi_link_slave
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "sim failed" >> $(LOG)
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
